//--- rv_pkg.sv
package rv_pkg;

    ////////////////////
    // sizes and credits
    ////////////////////
    localparam int MEM_WORDS    = 256;
    localparam int MEM_CREDITS  = 2;
    localparam int DBG_CREDITS  = 2;
    // one fetch or data access in flight at a time
    localparam int CORE_CREDITS = 1;
    localparam int DBG_PTR_W    = $clog2(DBG_CREDITS);
    localparam int NUM_REGS     = 32;

    // base opcodes of the supported subset
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;
    localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  mem_addr_t;
    // wide enough for any credit pool up to 3
    typedef logic [1:0]  cred_t;

    typedef enum logic {
        SRC_CORE = 1'b0,
        SRC_DBG  = 1'b1
    } src_e;

    typedef struct packed {
        logic      valid;
        logic      write;
        src_e      src;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    // a valid response also returns one credit to src
    typedef struct packed {
        logic  valid;
        src_e  src;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_FWAIT,
        S_EXEC,
        S_MWAIT,
        S_HALT
    } core_state_e;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_e   alu_op;
        logic      alu_src_imm;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      branch;
        logic      branch_ne;
        logic      jump;
        wb_sel_e   wb_sel;
        logic      halt;
    } dec_t;

endpackage

//--- rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  word_t instr_i,
    output dec_t  dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    ////////////////////
    // immediates, all sign extended
    ////////////////////
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        // all controls off means no-op
        dec_o        = '0;
        dec_o.rs1    = instr_i[19:15];
        dec_o.rs2    = instr_i[24:20];
        dec_o.rd     = instr_i[11:7];
        dec_o.alu_op = ALU_ADD;
        dec_o.wb_sel = WB_ALU;
        case (opcode)
            OP_LUI: begin
                dec_o.imm         = imm_u;
                dec_o.alu_op      = ALU_PASSB;
                dec_o.alu_src_imm = 1'b1;
                dec_o.reg_write   = 1'b1;
            end
            OP_IMM: begin
                dec_o.imm         = imm_i;
                dec_o.alu_src_imm = 1'b1;
                dec_o.reg_write   = 1'b1;
                case (funct3)
                    3'b000: dec_o.alu_op = ALU_ADD;
                    3'b010: dec_o.alu_op = ALU_SLT;
                    3'b100: dec_o.alu_op = ALU_XOR;
                    3'b110: dec_o.alu_op = ALU_OR;
                    3'b111: dec_o.alu_op = ALU_AND;
                    // shifts by immediate not supported
                    default: dec_o.reg_write = 1'b0;
                endcase
            end
            OP_REG: begin
                dec_o.reg_write = 1'b1;
                case (funct3)
                    3'b000: dec_o.alu_op = funct7_b5 ? ALU_SUB : ALU_ADD;
                    3'b001: dec_o.alu_op = ALU_SLL;
                    3'b010: dec_o.alu_op = ALU_SLT;
                    3'b100: dec_o.alu_op = ALU_XOR;
                    3'b101: dec_o.alu_op = ALU_SRL;
                    3'b110: dec_o.alu_op = ALU_OR;
                    3'b111: dec_o.alu_op = ALU_AND;
                    default: dec_o.reg_write = 1'b0;
                endcase
            end
            OP_LOAD: begin
                // word loads only
                if (funct3 == 3'b010) begin
                    dec_o.imm         = imm_i;
                    dec_o.alu_src_imm = 1'b1;
                    dec_o.mem_read    = 1'b1;
                    dec_o.reg_write   = 1'b1;
                    dec_o.wb_sel      = WB_MEM;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    dec_o.imm         = imm_s;
                    dec_o.alu_src_imm = 1'b1;
                    dec_o.mem_write   = 1'b1;
                end
            end
            OP_BRANCH: begin
                // beq and bne compare through a subtract
                if (funct3[2:1] == 2'b00) begin
                    dec_o.imm       = imm_b;
                    dec_o.alu_op    = ALU_SUB;
                    dec_o.branch    = 1'b1;
                    dec_o.branch_ne = funct3[0];
                end
            end
            OP_JAL: begin
                dec_o.imm       = imm_j;
                dec_o.jump      = 1'b1;
                dec_o.reg_write = 1'b1;
                dec_o.wb_sel    = WB_PC4;
            end
            OP_SYSTEM: begin
                dec_o.halt = (instr_i == INSTR_EBREAK);
            end
            default: ;
        endcase
    end

endmodule

//--- rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  word_t   a_i,
    input  word_t   b_i,
    input  alu_op_e op_i,
    output word_t   y_o,
    output logic    zero_o
);

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            // signed compare, result in bit 0
            ALU_SLT: y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            // shift amount is the low five bits only
            ALU_SLL: y_o = a_i << b_i[4:0];
            ALU_SRL: y_o = a_i >> b_i[4:0];
            // lui passes the upper immediate through
            default: y_o = b_i;
        endcase
    end

    // equal operands give zero on sub, used by beq and bne
    assign zero_o = (y_o == '0);

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic      CPU_clk_i,
    input  logic      rstn_i,
    input  logic      we_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    input  reg_addr_t wa_i,
    input  word_t     wd_i,
    output word_t     rd1_o,
    output word_t     rd2_o
);

    word_t rf_q [NUM_REGS];

    // synchronous write that never touches x0
    always_ff @(posedge CPU_clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin
            rf_q[wa_i] <= wd_i;
        end
    end

    // asynchronous reads
    // x0 keeps its reset zero
    assign rd1_o = rf_q[ra1_i];
    assign rd2_o = rf_q[ra2_i];

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic     CPU_clk_i,
    input  logic     rstn_i,
    input  logic     run_i,
    input  logic     mem_gnt_i,
    input  mem_rsp_t mem_rsp_i,
    output mem_req_t mem_req_o,
    output logic     halted_o,
    output word_t    pc_o
);

    core_state_e state_q;
    word_t       pc_q;
    word_t       instr_q;
    word_t       pc_plus4;
    word_t       pc_target;
    word_t       rd1;
    word_t       rd2;
    word_t       alu_b;
    word_t       alu_y;
    word_t       wd;
    dec_t        dec;
    logic        alu_zero;
    logic        take_branch;
    logic        rf_we;
    logic        req_taken;
    logic        mreq_pend_q;
    cred_t       cred_q;

    ////////////////////
    // datapath
    ////////////////////
    rv_decode u_decode (
        .instr_i (instr_q),
        .dec_o   (dec)
    );

    rv_regfile u_regfile (
        .CPU_clk_i (CPU_clk_i),
        .rstn_i    (rstn_i),
        .we_i      (rf_we),
        .ra1_i     (dec.rs1),
        .ra2_i     (dec.rs2),
        .wa_i      (dec.rd),
        .wd_i      (wd),
        .rd1_o     (rd1),
        .rd2_o     (rd2)
    );

    assign alu_b = dec.alu_src_imm ? dec.imm : rd2;

    rv_alu u_alu (
        .a_i    (rd1),
        .b_i    (alu_b),
        .op_i   (dec.alu_op),
        .y_o    (alu_y),
        .zero_o (alu_zero)
    );

    assign pc_plus4    = pc_q + 32'd4;
    assign pc_target   = pc_q + dec.imm;
    // jal always taken, branches on zero flag
    assign take_branch = dec.jump | (dec.branch & (alu_zero ^ dec.branch_ne));

    always_comb begin
        case (dec.wb_sel)
            WB_MEM:  wd = mem_rsp_i.rdata;
            WB_PC4:  wd = pc_plus4;
            default: wd = alu_y;
        endcase
    end

    // alu results in EXEC, load data when the response lands
    assign rf_we = dec.reg_write &
                   (((state_q == S_EXEC) & ~dec.mem_read) |
                    ((state_q == S_MWAIT) & mem_rsp_i.valid));

    ////////////////////
    // memory requester
    ////////////////////
    always_comb begin
        mem_req_o     = '0;
        mem_req_o.src = SRC_CORE;
        if (state_q == S_FETCH) begin
            mem_req_o.valid = (cred_q != '0);
            mem_req_o.addr  = pc_q[9:2];
        end else if (state_q == S_MWAIT) begin
            // operands stay stable, instr_q held until FETCH
            mem_req_o.valid = mreq_pend_q & (cred_q != '0);
            mem_req_o.write = dec.mem_write;
            mem_req_o.addr  = alu_y[9:2];
            mem_req_o.wdata = rd2;
        end
    end

    assign req_taken = mem_req_o.valid & mem_gnt_i;

    ////////////////////
    // control FSM
    ////////////////////
    always_ff @(posedge CPU_clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= S_IDLE;
            pc_q        <= '0;
            mreq_pend_q <= 1'b0;
            cred_q      <= cred_t'(CORE_CREDITS);
        end else begin
            // spend on request, refund on response
            cred_q <= cred_q - cred_t'(req_taken) + cred_t'(mem_rsp_i.valid);
            case (state_q)
                S_IDLE: begin
                    if (run_i) state_q <= S_FETCH;
                end
                S_FETCH: begin
                    if (req_taken) state_q <= S_FWAIT;
                end
                S_FWAIT: begin
                    if (mem_rsp_i.valid) state_q <= S_EXEC;
                end
                S_EXEC: begin
                    if (dec.halt) begin
                        // pc stays on the ebreak
                        state_q <= S_HALT;
                    end else if (dec.mem_read | dec.mem_write) begin
                        mreq_pend_q <= 1'b1;
                        state_q     <= S_MWAIT;
                    end else begin
                        pc_q    <= take_branch ? pc_target : pc_plus4;
                        state_q <= S_FETCH;
                    end
                end
                S_MWAIT: begin
                    if (req_taken) mreq_pend_q <= 1'b0;
                    if (mem_rsp_i.valid) begin
                        pc_q    <= pc_plus4;
                        state_q <= S_FETCH;
                    end
                end
                // halted until reset
                default: ;
            endcase
        end
    end

    // instruction latch
    always_ff @(posedge CPU_clk_i) begin
        if ((state_q == S_FWAIT) && mem_rsp_i.valid) begin
            instr_q <= mem_rsp_i.rdata;
        end
    end

    assign halted_o = (state_q == S_HALT);
    assign pc_o     = pc_q;

    // arbiter routing plus memory latency must land only in a wait state
    a_rsp_in_wait: assert property (@(posedge CPU_clk_i) disable iff (!rstn_i)
        mem_rsp_i.valid |-> (state_q inside {S_FWAIT, S_MWAIT}));

endmodule

//--- dbg_port.sv
`timescale 1ns/1ps

module dbg_port import rv_pkg::*; (
    input  logic     CPU_clk_i,
    input  logic     rstn_i,
    input  mem_req_t dbg_req_i,
    input  logic     mem_gnt_i,
    input  mem_rsp_t mem_rsp_i,
    output mem_req_t mem_req_o,
    output mem_rsp_t dbg_rsp_o
);

    // request queue, one slot per outside credit
    mem_req_t               fifo_q [DBG_CREDITS];
    logic [DBG_PTR_W-1:0]   wr_ptr_q;
    logic [DBG_PTR_W-1:0]   rd_ptr_q;
    cred_t                  count_q;
    logic                   push;
    logic                   pop;

    assign push = dbg_req_i.valid;
    assign pop  = mem_req_o.valid & mem_gnt_i;

    always_ff @(posedge CPU_clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + cred_t'(push) - cred_t'(pop);
        end
    end

    always_ff @(posedge CPU_clk_i) begin
        if (push) fifo_q[wr_ptr_q] <= dbg_req_i;
    end

    // oldest entry, retagged as debug
    always_comb begin
        mem_req_o       = fifo_q[rd_ptr_q];
        mem_req_o.valid = (count_q != '0);
        mem_req_o.src   = SRC_DBG;
    end

    // responses come back in order, nothing to reorder
    assign dbg_rsp_o = mem_rsp_i;

    // full queue means the outside world spent a credit it did not hold
    a_no_overflow: assert property (@(posedge CPU_clk_i) disable iff (!rstn_i)
        dbg_req_i.valid |-> (count_q < cred_t'(DBG_CREDITS)));

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import rv_pkg::*; (
    input  logic     CPU_clk_i,
    input  logic     rstn_i,
    input  mem_req_t core_req_i,
    input  mem_req_t dbg_req_i,
    input  mem_rsp_t mem_rsp_i,
    output logic     core_gnt_o,
    output logic     dbg_gnt_o,
    output mem_req_t mem_req_o,
    output mem_rsp_t core_rsp_o,
    output mem_rsp_t dbg_rsp_o
);

    cred_t cred_q;
    src_e  last_q;
    logic  has_cred;

    ////////////////////
    // round robin grant
    ////////////////////
    assign has_cred = (cred_q != '0);
    // on a tie the side not granted last wins
    assign core_gnt_o = has_cred & core_req_i.valid &
                        (~dbg_req_i.valid | (last_q == SRC_DBG));
    assign dbg_gnt_o  = has_cred & dbg_req_i.valid &
                        (~core_req_i.valid | (last_q == SRC_CORE));

    always_comb begin
        mem_req_o       = dbg_gnt_o ? dbg_req_i : core_req_i;
        mem_req_o.valid = core_gnt_o | dbg_gnt_o;
        mem_req_o.src   = dbg_gnt_o ? SRC_DBG : SRC_CORE;
    end

    // response routing by tag
    always_comb begin
        core_rsp_o       = mem_rsp_i;
        core_rsp_o.valid = mem_rsp_i.valid & (mem_rsp_i.src == SRC_CORE);
        dbg_rsp_o        = mem_rsp_i;
        dbg_rsp_o.valid  = mem_rsp_i.valid & (mem_rsp_i.src == SRC_DBG);
    end

    always_ff @(posedge CPU_clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cred_q <= cred_t'(MEM_CREDITS);
            // core wins the first tie
            last_q <= SRC_DBG;
        end else begin
            cred_q <= cred_q - cred_t'(mem_req_o.valid) + cred_t'(mem_rsp_i.valid);
            if (core_gnt_o) begin
                last_q <= SRC_CORE;
            end else if (dbg_gnt_o) begin
                last_q <= SRC_DBG;
            end
        end
    end

    // an underflow wraps past MEM_CREDITS, so one bound covers both sides
    a_cred_range: assert property (@(posedge CPU_clk_i) disable iff (!rstn_i)
        cred_q <= cred_t'(MEM_CREDITS));

endmodule

//--- unified_mem.sv
`timescale 1ns/1ps

module unified_mem import rv_pkg::*; (
    input  logic     CPU_clk_i,
    input  logic     rstn_i,
    input  mem_req_t req_i,
    output mem_rsp_t rsp_o
);

    word_t mem_q [MEM_WORDS];
    logic  rsp_valid_q;
    src_e  rsp_src_q;
    word_t rsp_data_q;

    // every accepted request answers next cycle
    always_ff @(posedge CPU_clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge CPU_clk_i) begin
        if (req_i.valid) begin
            rsp_src_q <= req_i.src;
            if (req_i.write) begin
                mem_q[req_i.addr] <= req_i.wdata;
                // write ack carries no data
                rsp_data_q <= '0;
            end else begin
                rsp_data_q <= mem_q[req_i.addr];
            end
        end
    end

    assign rsp_o = '{valid: rsp_valid_q, src: rsp_src_q, rdata: rsp_data_q};

endmodule

//--- rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
    input  logic     CPU_clk_i,
    input  logic     rstn_i,
    input  logic     run_i,
    input  mem_req_t dbg_req_i,
    output mem_rsp_t dbg_rsp_o,
    output logic     halted_o,
    output word_t    pc_o
);

    mem_req_t core_req;
    mem_req_t dbg_mreq;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    mem_rsp_t core_rsp;
    mem_rsp_t dbg_mrsp;
    logic     core_gnt;
    logic     dbg_gnt;

    ////////////////////
    // requesters
    ////////////////////
    rv_core u_core (
        .CPU_clk_i (CPU_clk_i),
        .rstn_i    (rstn_i),
        .run_i     (run_i),
        .mem_gnt_i (core_gnt),
        .mem_rsp_i (core_rsp),
        .mem_req_o (core_req),
        .halted_o  (halted_o),
        .pc_o      (pc_o)
    );

    dbg_port u_dbg (
        .CPU_clk_i (CPU_clk_i),
        .rstn_i    (rstn_i),
        .dbg_req_i (dbg_req_i),
        .mem_gnt_i (dbg_gnt),
        .mem_rsp_i (dbg_mrsp),
        .mem_req_o (dbg_mreq),
        .dbg_rsp_o (dbg_rsp_o)
    );

    ////////////////////
    // shared memory side
    ////////////////////
    mem_arbiter u_arb (
        .CPU_clk_i  (CPU_clk_i),
        .rstn_i     (rstn_i),
        .core_req_i (core_req),
        .dbg_req_i  (dbg_mreq),
        .mem_rsp_i  (mem_rsp),
        .core_gnt_o (core_gnt),
        .dbg_gnt_o  (dbg_gnt),
        .mem_req_o  (mem_req),
        .core_rsp_o (core_rsp),
        .dbg_rsp_o  (dbg_mrsp)
    );

    unified_mem u_mem (
        .CPU_clk_i (CPU_clk_i),
        .rstn_i    (rstn_i),
        .req_i     (mem_req),
        .rsp_o     (mem_rsp)
    );

endmodule

//--- tb_rv_core_top.sv
`timescale 1ns/1ps

module tb_rv_core_top import rv_pkg::*; ();

    localparam int  CLK_PERIOD = 8;
    localparam int  PROG_MAX   = 64;
    localparam int  NUM_RES    = 22;
    // debug ops for random fill and readback, program load and result readback
    localparam int  DBG_OPS    = 64 * 2 + PROG_MAX + NUM_RES;
    // up to 3 idle cycles plus queue and grant wait per op and 12 cycles per instruction
    localparam int  WD_CYCLES  = 10 + DBG_OPS * 8 + PROG_MAX * 2 * 12 + 200;

    logic     CPU_clk;
    logic     rstn;
    logic     run;
    mem_req_t dbg_req;
    mem_rsp_t dbg_rsp;
    logic     halted;
    word_t    pc;

    // lfsr and expected-response bookkeeping
    word_t    lfsr_q;
    word_t    exp_mem [1024];
    logic [9:0] exp_wr;
    logic [9:0] exp_rd;
    word_t    exp_head;
    int       credits;
    logic     idle_phase;
    int       data_errs;
    int       proto_errs;

    // program image and its reference results
    word_t    prog [PROG_MAX];
    int       np;
    word_t    rm [32];
    word_t    res_exp [NUM_RES];
    word_t    rand_data [64];
    word_t    halt_pc;

    rv_core_top dut0 (
        .CPU_clk_i (CPU_clk),
        .rstn_i    (rstn),
        .run_i     (run),
        .dbg_req_i (dbg_req),
        .dbg_rsp_o (dbg_rsp),
        .halted_o  (halted),
        .pc_o      (pc)
    );

    initial begin
        CPU_clk = 1'b0;
        forever #(CLK_PERIOD / 2) CPU_clk = ~CPU_clk;
    end

    ////////////////////
    // random source
    ////////////////////
    function automatic logic lfsr_step();
        logic fb;
        // taps 32 22 2 1
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    ////////////////////
    // RV32I encoders
    ////////////////////
    function automatic word_t enc_i(input word_t imm, input int rs1, input logic [2:0] f3,
                                    input int rd);
        return {imm[11:0], 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    // sw and lw with word accesses only
    function automatic word_t enc_s(input word_t imm, input int rs2, input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_lw(input word_t imm, input int rs1, input int rd);
        return {imm[11:0], 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic word_t enc_b(input word_t imm, input int rs2, input int rs1,
                                    input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(input word_t imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic put(input word_t instr);
        prog[np] = instr;
        np++;
    endtask

    // program plus reference register values
    task automatic build_program();
        int jal_idx;
        np = 0;
        put({20'h12345, 5'd1, 7'b0110111});
        rm[1] = 32'h12345 << 12;
        put(enc_i(-7, 0, 3'b000, 2));
        rm[2] = 32'd0 - 32'd7;
        put(enc_i(32'h678, 1, 3'b000, 3));
        rm[3] = rm[1] + 32'h678;
        put(enc_i(32'h0f0, 3, 3'b111, 4));
        rm[4] = rm[3] & 32'h0f0;
        put(enc_i(32'h505, 4, 3'b110, 5));
        rm[5] = rm[4] | 32'h505;
        put(enc_i(-1, 3, 3'b100, 6));
        rm[6] = rm[3] ^ 32'hffff_ffff;
        put(enc_i(5, 2, 3'b010, 7));
        rm[7] = ($signed(rm[2]) < 5) ? 32'd1 : 32'd0;
        put(enc_r(7'h00, 2, 3, 3'b000, 8));
        rm[8] = rm[3] + rm[2];
        put(enc_r(7'h20, 3, 4, 3'b000, 9));
        rm[9] = rm[4] - rm[3];
        put(enc_r(7'h00, 6, 3, 3'b111, 10));
        rm[10] = rm[3] & rm[6];
        put(enc_r(7'h00, 5, 4, 3'b110, 11));
        rm[11] = rm[4] | rm[5];
        put(enc_r(7'h00, 5, 3, 3'b100, 12));
        rm[12] = rm[3] ^ rm[5];
        put(enc_r(7'h00, 2, 3, 3'b010, 13));
        rm[13] = ($signed(rm[3]) < $signed(rm[2])) ? 32'd1 : 32'd0;
        put(enc_r(7'h00, 4, 3, 3'b001, 14));
        rm[14] = rm[3] << rm[4][4:0];
        put(enc_r(7'h00, 7, 6, 3'b101, 15));
        rm[15] = rm[6] >> rm[7][4:0];
        // results to words 64 to 78
        for (int i = 1; i <= 15; i++) begin
            put(enc_s(256 + 4 * (i - 1), i, 0));
            res_exp[i - 1] = rm[i];
        end
        // store, load back, store again
        put(enc_s(316, 8, 0));
        put(enc_lw(316, 0, 16));
        put(enc_s(320, 16, 0));
        res_exp[15] = rm[8];
        res_exp[16] = rm[8];
        put(enc_s(324, 8, 0));
        res_exp[17] = rm[8];
        // bne loop runs until the counter reaches 5
        put(enc_i(0, 0, 3'b000, 17));
        put(enc_i(5, 0, 3'b000, 18));
        put(enc_i(1, 17, 3'b000, 17));
        put(enc_b(-4, 18, 17, 3'b001));
        put(enc_s(328, 17, 0));
        res_exp[18] = 32'd5;
        // taken beq skips the overwrite
        put(enc_i(1, 0, 3'b000, 19));
        put(enc_b(8, 18, 17, 3'b000));
        put(enc_i(99, 0, 3'b000, 19));
        put(enc_s(332, 19, 0));
        res_exp[19] = 32'd1;
        // jal links to its own address plus 4
        jal_idx = np;
        put(enc_j(8, 20));
        put(enc_i(1, 0, 3'b000, 21));
        put(enc_s(336, 20, 0));
        put(enc_s(340, 21, 0));
        res_exp[20] = 32'(4 * jal_idx + 4);
        res_exp[21] = 32'd0;
        halt_pc = 32'(4 * np);
        put(32'h0010_0073);
    endtask

    ////////////////////
    // debug driver
    ////////////////////
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge CPU_clk);
            #1;
        end
    endtask

    task automatic dbg_access(input logic wr, input int waddr, input word_t wdata,
                              input word_t exp);
        while (credits == 0) begin
            @(posedge CPU_clk);
            #1;
        end
        idle_phase    = 1'b0;
        dbg_req.valid = 1'b1;
        dbg_req.write = wr;
        dbg_req.src   = SRC_DBG;
        dbg_req.addr  = mem_addr_t'(waddr);
        dbg_req.wdata = wdata;
        exp_mem[exp_wr] = exp;
        exp_wr  = exp_wr + 1'b1;
        credits = credits - 1;
        @(posedge CPU_clk);
        #1;
        dbg_req.valid = 1'b0;
    endtask

    task automatic drain();
        while (credits != DBG_CREDITS) begin
            @(posedge CPU_clk);
            #1;
        end
    endtask

    // each response returns one credit
    always @(posedge CPU_clk) begin
        if (rstn && dbg_rsp.valid) begin
            exp_rd  = exp_rd + 1'b1;
            credits = credits + 1;
        end
    end

    assign exp_head = exp_mem[exp_rd];

    ////////////////////
    // checks
    ////////////////////
    a_rsp_data: assert property (@(posedge CPU_clk) disable iff (!rstn)
        dbg_rsp.valid |-> (dbg_rsp.rdata == exp_head))
    else begin
        data_errs++;
        $display("error: dbg_rsp_o.rdata got %h expected %h",
                 $sampled(dbg_rsp.rdata), $sampled(exp_head));
    end

    a_rsp_owed: assert property (@(posedge CPU_clk) disable iff (!rstn)
        dbg_rsp.valid |-> (exp_rd != exp_wr))
    else begin
        proto_errs++;
        $display("debug response arrived with no request outstanding");
    end

    a_quiet_idle: assert property (@(posedge CPU_clk) disable iff (!rstn)
        idle_phase |-> !dbg_rsp.valid)
    else begin
        proto_errs++;
        $display("debug response seen before any debug request");
    end

    a_no_halt: assert property (@(posedge CPU_clk) disable iff (!rstn)
        !run |-> !halted)
    else begin
        proto_errs++;
        $display("core halted while run was low");
    end

    a_pc_idle: assert property (@(posedge CPU_clk) disable iff (!rstn)
        !run |-> (pc == '0))
    else begin
        data_errs++;
        $display("error: pc_o got %h expected %h", $sampled(pc), 32'h0);
    end

    a_halt_pc: assert property (@(posedge CPU_clk) disable iff (!rstn)
        halted |-> (pc == halt_pc))
    else begin
        data_errs++;
        $display("error: pc_o got %h expected %h", $sampled(pc), $sampled(halt_pc));
    end

    // hang guard
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: run still busy after %0d cycles", WD_CYCLES);
        $display("errors: data %0d, protocol %0d", data_errs, proto_errs);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        int k;
        rstn       = 1'b0;
        run        = 1'b0;
        dbg_req    = '0;
        lfsr_q     = 32'h897a170c;
        exp_wr     = '0;
        exp_rd     = '0;
        credits    = DBG_CREDITS;
        idle_phase = 1'b1;
        data_errs  = 0;
        proto_errs = 0;
        halt_pc    = '0;
        repeat (10) @(posedge CPU_clk);
        #1;
        rstn = 1'b1;
        idle_cycles(5);

        // random fill back to back then readback with random gaps
        for (int i = 0; i < 64; i++) begin
            rand_data[i] = rand_bits(32);
            dbg_access(1'b1, 128 + i, rand_data[i], '0);
        end
        for (int i = 0; i < 64; i++) begin
            idle_cycles(int'(rand_bits(2)));
            dbg_access(1'b0, 128 + i, '0, rand_data[i]);
        end
        drain();

        build_program();
        for (int i = 0; i < np; i++) begin
            dbg_access(1'b1, i, prog[i], '0);
        end
        drain();

        // debug traffic competes with the running core
        run = 1'b1;
        while (!halted) begin
            idle_cycles(int'(rand_bits(2)));
            k = int'(rand_bits(6));
            dbg_access(1'b0, 128 + k, '0, rand_data[k]);
        end
        drain();

        for (int i = 0; i < NUM_RES; i++) begin
            dbg_access(1'b0, 64 + i, '0, res_exp[i]);
        end
        drain();
        idle_cycles(2);

        a_all_done: assert (exp_rd == exp_wr && halted)
        else begin
            proto_errs++;
            $display("run ended with missing responses or core not halted");
        end

        $display("errors: data %0d, protocol %0d", data_errs, proto_errs);
        if (data_errs + proto_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- rv_core_top.f
rv_pkg.sv
rv_decode.sv
rv_alu.sv
rv_regfile.sv
rv_core.sv
dbg_port.sv
mem_arbiter.sv
unified_mem.sv
rv_core_top.sv
tb_rv_core_top.sv
